// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pc_subsys
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0

FLIST    := flist.f
SOURCES  := $(shell grep -v '^+' $(FLIST))
DATA     := testbench/pc_input.txt
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
PASS_MSG := Finished with no errors

.PHONY: all build run check clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN) $(DATA)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
logic/pc_pkg.sv
logic/instr_decode.sv
logic/serial_sequencer.sv
logic/operand_serializer.sv
logic/pc_update.sv
logic/rd_collect.sv
logic/pc_subsys_top.sv
testbench/tb_pc_subsys.sv

// File: logic/instr_decode.sv
`timescale 1ns/1ns

module instr_decode (
   input  pc_pkg::instr_t i_instr,
   input  logic           i_branch_taken,
   output logic           o_jump,
   output logic           o_jal_or_jalr,
   output logic           o_utype,
   output logic           o_pc_rel,
   output logic           o_writes_rd
);
   import pc_pkg::*;

   opcode_t opcode;
   logic    is_lui;
   logic    is_auipc;
   logic    is_jal;
   logic    is_jalr;
   logic    is_branch;

   assign opcode = i_instr[6:0];

   assign is_lui    = (opcode == op_lui);
   assign is_auipc  = (opcode == op_auipc);
   assign is_jal    = (opcode == op_jal);
   assign is_jalr   = (opcode == op_jalr);
   assign is_branch = (opcode == op_branch);

   // the branch level comes from the comparator outside and must stay steady through the run
   assign o_jump = is_jal | is_jalr | (is_branch & i_branch_taken);

   // rd gets PC+4 for both jump forms
   assign o_jal_or_jalr = is_jal | is_jalr;

   // LUI and AUIPC put the upper immediate on the rd stream
   assign o_utype = is_lui | is_auipc;

   // AUIPC, JAL and branches add their offset to the current PC
   // JALR takes its base from rs1 instead
   assign o_pc_rel = is_auipc | is_jal | is_branch;

   assign o_writes_rd = is_lui | is_auipc | is_jal | is_jalr;

endmodule

// File: logic/operand_serializer.sv
`timescale 1ns/1ns

module operand_serializer (
   input  logic           clk,
   input  logic           i_arst_n,
   input  logic           i_load,
   input  logic           i_pc_en,
   input  pc_pkg::instr_t i_instr,
   input  pc_pkg::word_t  i_rs1,
   output pc_pkg::instr_t o_instr,
   output logic           o_imm,
   output logic           o_buf
);
   import pc_pkg::*;

   opcode_t load_op;
   word_t   imm_nxt;
   word_t   imm_r;
   word_t   rs1_r;
   logic    is_jalr;
   logic    base_sum;
   logic    base_cy;
   logic    base_cy_r;

   assign load_op = i_instr[6:0];

   // immediate for the format of the incoming instruction
   always_comb begin
      case (load_op)
         op_lui, op_auipc: imm_nxt = {i_instr[31:12], 12'b0};
         op_jal:           imm_nxt = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                                      i_instr[30:21], 1'b0};
         op_branch:        imm_nxt = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                                      i_instr[11:8], 1'b0};
         default:          imm_nxt = {{20{i_instr[31]}}, i_instr[31:20]};
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_load) begin
         o_instr <= i_instr;
         imm_r   <= imm_nxt;
         rs1_r   <= i_rs1;
      end else if (i_pc_en) begin
         imm_r <= {1'b0, imm_r[xlen-1:1]};
         rs1_r <= {1'b0, rs1_r[xlen-1:1]};
      end
   end

   assign o_imm = imm_r[0];

   // rs1 + imm, one bit per run cycle
   assign {base_cy, base_sum} = {1'b0, rs1_r[0]} + {1'b0, imm_r[0]} + {1'b0, base_cy_r};

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n)
         base_cy_r <= 1'b0;
      else
         base_cy_r <= i_pc_en & base_cy;
   end

   assign is_jalr = (o_instr[6:0] == op_jalr);
   assign o_buf   = is_jalr ? base_sum : imm_r[0];

endmodule

// File: logic/pc_pkg.sv
package pc_pkg;

   // data and address width of the core
   localparam int xlen = 32;

   typedef logic [xlen-1:0] pc_t;
   typedef logic [xlen-1:0] instr_t;
   typedef logic [xlen-1:0] word_t;

   // bit position inside a serial run, one per clock
   typedef logic [4:0] cnt_t;

   typedef logic [6:0] opcode_t;

   localparam pc_t reset_pc = '0;

   // major opcodes that touch the PC path
   localparam opcode_t op_lui    = 7'b0110111;
   localparam opcode_t op_auipc  = 7'b0010111;
   localparam opcode_t op_jal    = 7'b1101111;
   localparam opcode_t op_jalr   = 7'b1100111;
   localparam opcode_t op_branch = 7'b1100011;

   // fetch an instruction, wait for its operands, then run 32 serial cycles
   typedef enum logic [1:0] {
      s_fetch,
      s_wait,
      s_run
   } seq_state_t;

endpackage

// File: logic/pc_subsys_top.sv
`timescale 1ns/1ns

module pc_subsys_top (
   input  logic           clk,
   input  logic           i_arst_n,
   input  logic           i_instr_valid,
   input  pc_pkg::instr_t i_instr,
   input  pc_pkg::word_t  i_rs1,
   input  logic           i_branch_taken,
   input  logic           i_ibus_ack,
   output pc_pkg::pc_t    o_ibus_adr,
   output logic           o_ibus_cyc,
   output logic           o_busy,
   output logic           o_rd_valid,
   output pc_pkg::word_t  o_rd_data,
   output logic           o_misaligned
);
   import pc_pkg::*;

   instr_t instr_q;
   logic   jump;
   logic   jal_or_jalr;
   logic   utype;
   logic   pc_rel;
   logic   writes_rd;
   logic   ibus_ack_seen;
   logic   load;
   logic   pc_en;
   logic   cnt2;
   logic   cnt12to31;
   logic   cnt_done;
   logic   imm_bit;
   logic   buf_bit;
   logic   rd_bit;
   logic   target_bit;

   instr_decode u_decode (
      .i_instr        (instr_q),
      .i_branch_taken (i_branch_taken),
      .o_jump         (jump),
      .o_jal_or_jalr  (jal_or_jalr),
      .o_utype        (utype),
      .o_pc_rel       (pc_rel),
      .o_writes_rd    (writes_rd)
   );

   serial_sequencer u_seq (
      .clk             (clk),
      .i_arst_n        (i_arst_n),
      .i_ibus_ack      (i_ibus_ack),
      .i_instr_valid   (i_instr_valid),
      .o_ibus_ack_seen (ibus_ack_seen),
      .o_load          (load),
      .o_pc_en         (pc_en),
      .o_cnt2          (cnt2),
      .o_cnt12to31     (cnt12to31),
      .o_cnt_done      (cnt_done),
      .o_busy          (o_busy)
   );

   operand_serializer u_ops (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_load   (load),
      .i_pc_en  (pc_en),
      .i_instr  (i_instr),
      .i_rs1    (i_rs1),
      .o_instr  (instr_q),
      .o_imm    (imm_bit),
      .o_buf    (buf_bit)
   );

   pc_update u_pc (
      .clk             (clk),
      .i_arst_n        (i_arst_n),
      .i_pc_en         (pc_en),
      .i_cnt12to31     (cnt12to31),
      .i_cnt2          (cnt2),
      .i_jump          (jump),
      .i_jal_or_jalr   (jal_or_jalr),
      .i_utype         (utype),
      .i_pc_rel        (pc_rel),
      .i_imm           (imm_bit),
      .i_buf           (buf_bit),
      .i_ibus_ack_seen (ibus_ack_seen),
      .o_rd            (rd_bit),
      .o_target_bit    (target_bit),
      .o_ibus_adr      (o_ibus_adr),
      .o_ibus_cyc      (o_ibus_cyc)
   );

   rd_collect u_rd (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_pc_en      (pc_en),
      .i_cnt_done   (cnt_done),
      .i_cnt2       (cnt2),
      .i_rd_bit     (rd_bit),
      .i_target_bit (target_bit),
      .i_writes_rd  (writes_rd),
      .i_jump       (jump),
      .o_rd_valid   (o_rd_valid),
      .o_rd_data    (o_rd_data),
      .o_misaligned (o_misaligned)
   );

endmodule

// File: logic/pc_update.sv
`timescale 1ns/1ns

module pc_update (
   input  logic        clk,
   input  logic        i_arst_n,
   input  logic        i_pc_en,
   input  logic        i_cnt12to31,
   input  logic        i_cnt2,
   input  logic        i_jump,
   input  logic        i_jal_or_jalr,
   input  logic        i_utype,
   input  logic        i_pc_rel,
   input  logic        i_imm,
   input  logic        i_buf,
   input  logic        i_ibus_ack_seen,
   output logic        o_rd,
   output logic        o_target_bit,
   output pc_pkg::pc_t o_ibus_adr,
   output logic        o_ibus_cyc
);
   import pc_pkg::*;

   logic en_pc_r;
   logic pc_bit;
   logic new_pc;
   logic pc_plus_4;
   logic pc_plus_4_cy;
   logic pc_plus_4_cy_r;
   logic offset_a;
   logic offset_b;
   logic pc_plus_offset;
   logic pc_plus_offset_cy;
   logic pc_plus_offset_cy_r;
   logic pc_plus_offset_aligned;

   // the PC register is the shift register and its LSB is the current bit
   assign pc_bit = o_ibus_adr[0];

   // adding 4 is a single one injected at bit 2
   assign {pc_plus_4_cy, pc_plus_4} = {1'b0, pc_bit} + {1'b0, i_cnt2} + {1'b0, pc_plus_4_cy_r};

   assign offset_a = i_pc_rel & pc_bit;

   // U-type immediates only have bits 12 and up
   assign offset_b = i_utype ? (i_imm & i_cnt12to31) : i_buf;

   assign {pc_plus_offset_cy, pc_plus_offset} =
      {1'b0, offset_a} + {1'b0, offset_b} + {1'b0, pc_plus_offset_cy_r};

   // en_pc_r is still low in the first run cycle, which clears bit 0 of the target
   assign pc_plus_offset_aligned = pc_plus_offset & en_pc_r;

   assign new_pc = i_jump ? pc_plus_offset_aligned : pc_plus_4;

   assign o_rd = (i_utype & pc_plus_offset_aligned) | (i_jal_or_jalr & pc_plus_4);

   assign o_target_bit = pc_plus_offset_aligned;

   // a new fetch is requested once a run has finished and until it is acknowledged
   assign o_ibus_cyc = en_pc_r & ~i_pc_en;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         en_pc_r             <= 1'b1;
         pc_plus_4_cy_r      <= 1'b0;
         pc_plus_offset_cy_r <= 1'b0;
         o_ibus_adr          <= reset_pc;
      end else begin
         pc_plus_4_cy_r      <= i_pc_en & pc_plus_4_cy;
         pc_plus_offset_cy_r <= i_pc_en & pc_plus_offset_cy;
         if (i_ibus_ack_seen | i_pc_en)
            en_pc_r <= i_pc_en;
         if (i_pc_en)
            o_ibus_adr <= {new_pc, o_ibus_adr[xlen-1:1]};
      end
   end

endmodule

// File: logic/rd_collect.sv
`timescale 1ns/1ns

module rd_collect (
   input  logic          clk,
   input  logic          i_arst_n,
   input  logic          i_pc_en,
   input  logic          i_cnt_done,
   input  logic          i_cnt2,
   input  logic          i_rd_bit,
   input  logic          i_target_bit,
   input  logic          i_writes_rd,
   input  logic          i_jump,
   output logic          o_rd_valid,
   output pc_pkg::word_t o_rd_data,
   output logic          o_misaligned
);
   import pc_pkg::*;

   logic prev_target_bit;

   // rd arrives LSB first, so it fills from the top
   always_ff @(posedge clk) begin
      if (i_pc_en) begin
         o_rd_data       <= {i_rd_bit, o_rd_data[xlen-1:1]};
         prev_target_bit <= i_target_bit;
      end
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_rd_valid   <= 1'b0;
         o_misaligned <= 1'b0;
      end else begin
         o_rd_valid <= i_cnt_done & i_writes_rd;
         // at count 2 the held bit is target bit 1
         if (i_cnt2)
            o_misaligned <= i_jump & prev_target_bit;
      end
   end

endmodule

// File: logic/serial_sequencer.sv
`timescale 1ns/1ns

module serial_sequencer (
   input  logic clk,
   input  logic i_arst_n,
   input  logic i_ibus_ack,
   input  logic i_instr_valid,
   output logic o_ibus_ack_seen,
   output logic o_load,
   output logic o_pc_en,
   output logic o_cnt2,
   output logic o_cnt12to31,
   output logic o_cnt_done,
   output logic o_busy
);
   import pc_pkg::*;

   seq_state_t state;
   seq_state_t state_nxt;
   cnt_t       cnt;
   logic       run;
   logic       last_bit;

   assign run      = (state == s_run);
   assign last_bit = (cnt == 5'd31);

   always_comb begin
      state_nxt = state;
      case (state)
         s_fetch: begin
            if (i_ibus_ack)
               state_nxt = s_wait;
         end
         s_wait: begin
            if (i_instr_valid)
               state_nxt = s_run;
         end
         s_run: begin
            if (last_bit)
               state_nxt = s_fetch;
         end
         default: state_nxt = s_fetch;
      endcase
   end

   // the counter wraps from 31 back to 0, so it is already clear for the next run
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state <= s_fetch;
         cnt   <= '0;
      end else begin
         state <= state_nxt;
         if (run)
            cnt <= cnt + 5'd1;
      end
   end

   assign o_ibus_ack_seen = i_ibus_ack & (state == s_fetch);
   assign o_load          = i_instr_valid & (state == s_wait);

   assign o_pc_en     = run;
   assign o_busy      = run;
   assign o_cnt2      = run & (cnt == 5'd2);
   assign o_cnt12to31 = run & (cnt >= 5'd12);
   assign o_cnt_done  = run & last_bit;

endmodule

// File: testbench/pc_input.txt
# columns in hex: instr rs1 taken next_pc rd_written rd_value misaligned
# rows run in order starting from the reset PC
00500093 00000000 0 00000004 0 00000000 0
123450b7 00000000 0 00000008 1 12345000 0
00010117 00000000 0 0000000c 1 00010008 0
10208063 00000000 0 00000010 0 00000000 0
02209063 00000000 1 00000030 0 00000000 0
fe20c8e3 00000000 1 00000020 0 00000000 0
040000ef 00000000 0 00000060 1 00000024 0
fc1ff0ef 00000000 0 00000020 1 00000064 0
100280e7 00001000 0 00001100 1 00000024 0
010280e7 00002001 0 00002010 1 00001104 0
ff8280e7 00003000 0 00002ff8 1 00002014 0
fffff197 00000000 0 00002ffc 1 00001ff8 0
002081b3 0000abcd 1 00003000 0 00000000 0
fffff237 00000000 0 00003004 1 fffff000 0
00208363 00000000 0 00003008 0 00000000 0
002280e7 00004000 0 00004002 1 0000300c 1
00500093 00000000 0 00004006 0 00000000 0
000010ef 00000000 0 00005006 1 0000400a 1
00028067 80000000 0 80000000 1 0000500a 0
80000097 00000000 0 80000004 1 00000000 0
fe20dee3 00000000 1 80000000 0 00000000 0
010280e7 fffffff0 0 00000000 1 80000004 0

// File: testbench/tb_pc_subsys.sv
`timescale 1ns/1ns

module tb_pc_subsys;
   import pc_pkg::*;

   logic   clk;
   logic   i_arst_n;
   logic   i_instr_valid;
   instr_t i_instr;
   word_t  i_rs1;
   logic   i_branch_taken;
   logic   i_ibus_ack;
   pc_t    o_ibus_adr;
   logic   o_ibus_cyc;
   logic   o_busy;
   logic   o_rd_valid;
   word_t  o_rd_data;
   logic   o_misaligned;

   int     seed = 61377;
   int     cycle_count;
   int     timeout_limit;
   pc_t    cur_pc;

   // one entry per line of the data file
   instr_t vec_instr[$];
   word_t  vec_rs1[$];
   logic   vec_taken[$];
   pc_t    vec_next[$];
   logic   vec_wr[$];
   word_t  vec_rd[$];
   logic   vec_mis[$];

   pc_subsys_top u_dut (
      .clk            (clk),
      .i_arst_n       (i_arst_n),
      .i_instr_valid  (i_instr_valid),
      .i_instr        (i_instr),
      .i_rs1          (i_rs1),
      .i_branch_taken (i_branch_taken),
      .i_ibus_ack     (i_ibus_ack),
      .o_ibus_adr     (o_ibus_adr),
      .o_ibus_cyc     (o_ibus_cyc),
      .o_busy         (o_busy),
      .o_rd_valid     (o_rd_valid),
      .o_rd_data      (o_rd_data),
      .o_misaligned   (o_misaligned)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Finished with errors");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic check_pc(input string name, input pc_t expected, input pc_t actual);
      if (actual !== expected)
         abort_run($sformatf("error at %0t ns: %s expected %h, got %h",
                             $time, name, expected, actual));
   endtask

   task automatic check_word(input string name, input word_t expected, input word_t actual);
      if (actual !== expected)
         abort_run($sformatf("error at %0t ns: %s expected %h, got %h",
                             $time, name, expected, actual));
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected)
         abort_run($sformatf("error at %0t ns: %s expected %b, got %b",
                             $time, name, expected, actual));
   endtask

   initial begin
      cycle_count = 0;
      forever begin
         @(posedge clk);
         cycle_count = cycle_count + 1;
         if (cycle_count >= timeout_limit)
            abort_run($sformatf("timeout: the run did not finish within %0d cycles",
                                timeout_limit));
      end
   end

   task automatic read_vectors();
      int          fd;
      int          fields;
      string       line;
      logic [31:0] f_instr, f_rs1, f_taken, f_next, f_wr, f_rd, f_mis;
      fd = $fopen("testbench/pc_input.txt", "r");
      if (fd == 0)
         abort_run("cannot open testbench/pc_input.txt for reading");
      while ($fgets(line, fd) != 0) begin
         // lines starting with # describe the columns
         if (line.len() < 2 || line[0] == "#")
            continue;
         fields = $sscanf(line, "%h %h %h %h %h %h %h",
                          f_instr, f_rs1, f_taken, f_next, f_wr, f_rd, f_mis);
         if (fields != 7)
            abort_run($sformatf("malformed line in pc_input.txt: %s", line));
         vec_instr.push_back(f_instr);
         vec_rs1.push_back(f_rs1);
         vec_taken.push_back(f_taken[0]);
         vec_next.push_back(f_next);
         vec_wr.push_back(f_wr[0]);
         vec_rd.push_back(f_rd);
         vec_mis.push_back(f_mis[0]);
      end
      $fclose(fd);
   endtask

   // holds off the acknowledge for a random number of cycles while the address stays put
   task automatic respond_fetch(input pc_t exp_adr);
      int wait_cycles;
      check_flag("o_ibus_cyc", 1'b1, o_ibus_cyc);
      check_pc("o_ibus_adr", exp_adr, o_ibus_adr);
      wait_cycles = $unsigned($random(seed)) % 4;
      repeat (wait_cycles) begin
         @(posedge clk);
         #1;
         check_flag("o_ibus_cyc", 1'b1, o_ibus_cyc);
         check_pc("o_ibus_adr", exp_adr, o_ibus_adr);
         check_flag("o_rd_valid", 1'b0, o_rd_valid);
      end
      i_ibus_ack = 1'b1;
      @(posedge clk);
      #1;
      i_ibus_ack = 1'b0;
      check_flag("o_ibus_cyc", 1'b0, o_ibus_cyc);
      check_flag("o_rd_valid", 1'b0, o_rd_valid);
   endtask

   task automatic issue_instruction(input instr_t instr, input word_t rs1, input logic taken);
      int wait_cycles;
      int run_cycles;
      wait_cycles = $unsigned($random(seed)) % 4;
      repeat (wait_cycles) begin
         @(posedge clk);
         #1;
         check_flag("o_ibus_cyc", 1'b0, o_ibus_cyc);
         check_flag("o_busy", 1'b0, o_busy);
      end
      i_instr        = instr;
      i_rs1          = rs1;
      i_branch_taken = taken;
      i_instr_valid  = 1'b1;
      @(posedge clk);
      #1;
      i_instr_valid = 1'b0;
      // operands are latched on the pulse, so scramble them for the rest of the run
      i_instr = $random(seed);
      i_rs1   = $random(seed);
      run_cycles = 1;
      while (!o_ibus_cyc && run_cycles <= 33) begin
         check_flag("o_busy", 1'b1, o_busy);
         check_flag("o_rd_valid", 1'b0, o_rd_valid);
         @(posedge clk);
         #1;
         run_cycles = run_cycles + 1;
      end
      if (run_cycles != 33)
         abort_run($sformatf("next fetch started %0d cycles after the instruction, not 33",
                             run_cycles));
   endtask

   initial begin
      i_arst_n       = 1'b0;
      i_instr_valid  = 1'b0;
      i_instr        = '0;
      i_rs1          = '0;
      i_branch_taken = 1'b0;
      i_ibus_ack     = 1'b0;
      read_vectors();
      timeout_limit = vec_instr.size() * 50 + 100;
      repeat (2) @(posedge clk);
      #1;
      i_arst_n = 1'b1;
      check_flag("o_ibus_cyc", 1'b1, o_ibus_cyc);
      check_pc("o_ibus_adr", reset_pc, o_ibus_adr);
      check_flag("o_rd_valid", 1'b0, o_rd_valid);
      check_flag("o_busy", 1'b0, o_busy);
      cur_pc = reset_pc;
      foreach (vec_instr[i]) begin
         respond_fetch(cur_pc);
         issue_instruction(vec_instr[i], vec_rs1[i], vec_taken[i]);
         check_pc("o_ibus_adr", vec_next[i], o_ibus_adr);
         check_flag("o_rd_valid", vec_wr[i], o_rd_valid);
         if (vec_wr[i])
            check_word("o_rd_data", vec_rd[i], o_rd_data);
         check_flag("o_misaligned", vec_mis[i], o_misaligned);
         check_flag("o_busy", 1'b0, o_busy);
         cur_pc = vec_next[i];
      end
      $display("Finished with no errors");
      $finish;
   end

endmodule
